// File: Makefile
# Verilator build and run for the ARC micro-datapath

VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
TOP        := data_path_tb
RTL_TOP    := data_path
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Regression failed
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu.sv
// ARC ALU and PSR flags

`timescale 1ns/1ps

module alu
	import arc_reg_pkg::*;
	import arc_alu_pkg::*;
(
	input  logic    clock_50,
	input  logic    arst_n,
	input  alu_op_t alu_op,
	input  word_t   bus_a,
	input  word_t   bus_b,
	output word_t   bus_c,
	output flags_t  flags
);

	// 33-bit sum of A and B, the top bit is the carry out
	logic [32:0] sum;

	// signed overflow of A plus B
	logic        sum_overflow;

	// flags computed from the current operation
	flags_t      next_flags;

	// ------------------------------
	// shared adder
	// ------------------------------

	// addcc and add both take their result from this adder
	assign sum = {1'b0, bus_a} + {1'b0, bus_b};

	// overflow when both operands have the same sign and the sum has the other one
	assign sum_overflow = (bus_a[31] == bus_b[31]) && (sum[31] != bus_a[31]);

	// ------------------------------
	// function select
	// ------------------------------

	// the logic operations come in pairs that differ only in the flag update
	always_comb begin
		case (alu_op)
			alu_andcc, alu_and: begin
				bus_c = bus_a & bus_b;
			end
			alu_orcc, alu_or: begin
				bus_c = bus_a | bus_b;
			end
			alu_orncc, alu_orn: begin
				bus_c = bus_a | ~bus_b;
			end
			alu_addcc, alu_add: begin
				bus_c = sum[31:0];
			end
			alu_srl: begin
				// shift amount is the low five bits of B, zeros come in at the top
				bus_c = bus_a >> bus_b[4:0];
			end
			alu_lshift2: begin
				bus_c = bus_a << 2;
			end
			alu_lshift10: begin
				// used with lshift2 to place the 22-bit sethi immediate
				bus_c = bus_a << 10;
			end
			alu_simm13: begin
				// keeps the 13-bit immediate of an instruction word, zero-extended
				bus_c = {19'b0, bus_a[12:0]};
			end
			alu_sext13: begin
				bus_c = {{19{bus_a[12]}}, bus_a[12:0]};
			end
			alu_inc: begin
				// inc of r0 gives the constant 1
				bus_c = bus_a + 32'd1;
			end
			alu_incpc: begin
				// step pc to the next word-aligned instruction
				bus_c = bus_a + 32'd4;
			end
			alu_rshift5: begin
				// arithmetic shift keeps the sign bit
				bus_c = word_t'($signed(bus_a) >>> 5);
			end
			default: begin
				bus_c = '0;
			end
		endcase
	end

	// ------------------------------
	// flag generation
	// ------------------------------

	// n and z follow the result for every operation
	// v and c only carry meaning for addcc and are zero otherwise
	always_comb begin
		next_flags = '0;
		next_flags[flag_n] = bus_c[31];
		next_flags[flag_z] = (bus_c == '0);
		if (alu_op == alu_addcc) begin
			next_flags[flag_v] = sum_overflow;
			next_flags[flag_c] = sum[32];
		end
	end

	// ------------------------------
	// PSR flag register
	// ------------------------------

	// only the condition-code operations load the flags, all others hold them
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (alu_is_cc(alu_op)) begin
			flags <= next_flags;
		end
	end

endmodule

// File: alu_asserts.sv
// ALU flag and bus checks

`timescale 1ns/1ps

module alu_asserts
	import arc_reg_pkg::*;
	import arc_alu_pkg::*;
(
	input logic    clock_50,
	input logic    arst_n,
	input alu_op_t alu_op,
	input word_t   bus_c,
	input flags_t  flags
);

	// count of failed assertions, read back by the testbench at the end of the run
	int failures = 0;

	// ------------------------------
	// PSR flags
	// ------------------------------

	// the twelve operations outside codes 0 to 3 leave the PSR alone
	flags_hold: assert property (@(posedge clock_50) disable iff (!arst_n)
		!(alu_op inside {alu_andcc, alu_orcc, alu_orncc, alu_addcc}) |=> $stable(flags))
	else begin
		$error("flags changed after a non-condition-code operation");
		failures = failures + 1;
	end

	// the PSR is cleared for as long as reset is held
	flags_reset: assert property (@(posedge clock_50) !arst_n |-> (flags == '0))
	else begin
		$error("flags not zero during reset");
		failures = failures + 1;
	end

	// ------------------------------
	// result bus
	// ------------------------------

	// every register is defined once reset is over, so bus C must be too
	bus_c_known: assert property (@(posedge clock_50) disable iff (!arst_n) !$isunknown(bus_c))
	else begin
		$error("bus C has unknown bits");
		failures = failures + 1;
	end

endmodule

// File: arc_alu_pkg.sv
// ARC ALU operation types

package arc_alu_pkg;

	// ------------------------------
	// ALU operation encoding
	// ------------------------------

	// codes 0 to 3 are the condition-code operations and update the PSR flags
	// the remaining twelve leave the flags as they are
	typedef enum logic [3:0] {
		alu_andcc    = 4'd0,
		alu_orcc     = 4'd1,
		alu_orncc    = 4'd2,
		alu_addcc    = 4'd3,
		alu_srl      = 4'd4,
		alu_and      = 4'd5,
		alu_or       = 4'd6,
		alu_orn      = 4'd7,
		alu_add      = 4'd8,
		alu_lshift2  = 4'd9,
		alu_lshift10 = 4'd10,
		alu_simm13   = 4'd11,
		alu_sext13   = 4'd12,
		alu_inc      = 4'd13,
		alu_incpc    = 4'd14,
		alu_rshift5  = 4'd15
	} alu_op_t;

	// true for the condition-code operations, whose two top code bits are zero
	function automatic logic alu_is_cc(input alu_op_t op);
		return (op[3:2] == 2'b00);
	endfunction

	// ------------------------------
	// condition flags
	// ------------------------------

	// PSR flags packed as n, z, v, c from the top bit down
	typedef logic [3:0] flags_t;

	// bit positions inside flags_t
	localparam int flag_n = 3;
	localparam int flag_z = 2;
	localparam int flag_v = 1;
	localparam int flag_c = 0;

endpackage

// File: arc_reg_pkg.sv
// ARC register file types

package arc_reg_pkg;

	// ------------------------------
	// data word
	// ------------------------------

	// one 32-bit ARC word, as carried on buses A, B and C and held in every register
	typedef logic [31:0] word_t;

	// ------------------------------
	// register selects
	// ------------------------------

	// a select names one of the 38 registers, values 38 to 63 name nothing
	typedef logic [5:0] reg_sel_t;

	// number of registers addressed by a select, r0 included
	localparam int reg_count = 38;

	// r0 to r31 use selects 0 to 31, the special registers follow them
	localparam reg_sel_t reg_pc = 6'd32;

	// first of the four temporaries t0 to t3 at selects 33 to 36
	localparam reg_sel_t reg_t0 = 6'd33;

	// instruction register, the last select in use
	localparam reg_sel_t reg_ir = 6'd37;

	// ------------------------------
	// instruction fields
	// ------------------------------

	// op field, ir bits 31:30
	typedef logic [1:0] op_t;

	// register number as found in the rd, rs1 and rs2 fields
	typedef logic [4:0] reg_addr_t;

	// op2 field of the branch and sethi formats, ir bits 24:22
	typedef logic [2:0] op2_t;

	// op3 field of the arithmetic and memory formats, ir bits 24:19
	typedef logic [5:0] op3_t;

endpackage

// File: data_path.sv
// ARC micro-datapath top level

`timescale 1ns/1ps

module data_path
	import arc_reg_pkg::*;
	import arc_alu_pkg::*;
#(
	// boot address loaded into pc on reset
	parameter word_t pc_reset_value = 32'h00000800
) (
	input  logic      clock_50,
	input  logic      arst_n,
	input  reg_sel_t  write_sel,
	input  reg_sel_t  read_sel_a,
	input  reg_sel_t  read_sel_b,
	input  alu_op_t   alu_op,
	output word_t     display_bus,
	output flags_t    flags,
	output op_t       ir_op,
	output reg_addr_t ir_rd,
	output op2_t      ir_op2,
	output op3_t      ir_op3,
	output reg_addr_t ir_rs1,
	output logic      ir_bit13,
	output reg_addr_t ir_rs2
);

	// ------------------------------
	// datapath buses
	// ------------------------------

	// A and B run from the register file to the ALU, C runs back
	word_t bus_a;
	word_t bus_b;
	word_t bus_c;

	// registers, write decode, read multiplexers and the ir field split
	register_file #(
		.pc_reset_value(pc_reset_value)
	) u_register_file (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.write_sel  (write_sel),
		.read_sel_a (read_sel_a),
		.read_sel_b (read_sel_b),
		.bus_c      (bus_c),
		.bus_a      (bus_a),
		.bus_b      (bus_b),
		.display_bus(display_bus),
		.ir_op      (ir_op),
		.ir_rd      (ir_rd),
		.ir_op2     (ir_op2),
		.ir_op3     (ir_op3),
		.ir_rs1     (ir_rs1),
		.ir_bit13   (ir_bit13),
		.ir_rs2     (ir_rs2)
	);

	// sixteen functions on A and B, with the PSR flags registered inside
	alu u_alu (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.alu_op  (alu_op),
		.bus_a   (bus_a),
		.bus_b   (bus_b),
		.bus_c   (bus_c),
		.flags   (flags)
	);

endmodule

// File: data_path_tb.sv
// ARC datapath testbench

`timescale 1ns/1ps

module data_path_tb
	import arc_reg_pkg::*;
	import arc_alu_pkg::*;
();

	// ------------------------------
	// run length
	// ------------------------------

	// a constant needs one clear, fifteen shifts and up to three inc per 2-bit chunk
	localparam int load_ops   = 64;
	localparam int load_count = 8;
	localparam int ir_count   = 3;
	localparam int alu_rounds = 3;
	// reset, then tests 1 to 5 in order, then the closing cycles
	localparam int max_ops = 3 + 1 + load_count * (load_ops + 2) + 5 + load_count
		+ alu_rounds * 16 + 22 + ir_count * load_ops + 2;
	localparam int watchdog_ns = (max_ops + 20) * 100;

	logic      clock_50;
	logic      arst_n;
	reg_sel_t  write_sel;
	reg_sel_t  read_sel_a;
	reg_sel_t  read_sel_b;
	alu_op_t   alu_op;
	word_t     display_bus;
	flags_t    flags;
	op_t       ir_op;
	reg_addr_t ir_rd;
	op2_t      ir_op2;
	op3_t      ir_op3;
	reg_addr_t ir_rs1;
	logic      ir_bit13;
	reg_addr_t ir_rs2;

	// model of the 38 registers and the PSR, entry 0 stays zero
	word_t       model_regs [0:reg_count-1];
	flags_t      model_flags;
	logic [31:0] lfsr_state = 32'h3e2d;
	logic        checking = 1'b0;
	string       test_name = "reset";
	// registers given random constants, later used as ALU operands
	reg_sel_t    targets [8] = '{6'd2, 6'd3, 6'd4, 6'd5, 6'd17, 6'd31, 6'd33, 6'd36};
	word_t       loaded [8];

	tb_clock_gen #(.period_ns(100)) clock_source (.clock(clock_50));

	data_path #(.pc_reset_value(32'h00000800)) dut (.*);

	bind alu alu_asserts alu_checks (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.alu_op  (alu_op),
		.bus_c   (bus_c),
		.flags   (flags)
	);

	// ------------------------------
	// reference model
	// ------------------------------

	function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			alu_andcc, alu_and: return a & b;
			alu_orcc, alu_or: return a | b;
			alu_orncc, alu_orn: return a | ~b;
			alu_addcc, alu_add: return a + b;
			alu_srl: return a >> b[4:0];
			alu_lshift2: return {a[29:0], 2'b00};
			alu_lshift10: return {a[21:0], 10'd0};
			alu_simm13: return a & 32'h00001fff;
			// bit 12 fills every bit from 13 up
			alu_sext13: return (a & 32'h00001fff) | (a[12] ? 32'hffffe000 : 32'h00000000);
			alu_inc: return a + 32'd1;
			alu_incpc: return a + 32'd4;
			// arithmetic shift, five copies of the sign come in at the top
			alu_rshift5: return {{5{a[31]}}, a[31:5]};
			default: return '0;
		endcase
	endfunction

	// overflow shows as a 64-bit signed sum that no longer fits the 32-bit result
	function automatic flags_t ref_flags(input alu_op_t op, input word_t a, input word_t b,
		input word_t r);
		flags_t f;
		longint s;
		longint u;
		f = '0;
		f[flag_n] = r[31];
		f[flag_z] = (r == 32'd0);
		if (op == alu_addcc) begin
			s = longint'($signed(a)) + longint'($signed(b));
			u = longint'(a) + longint'(b);
			f[flag_v] = (s != longint'($signed(r)));
			f[flag_c] = u[32];
		end
		return f;
	endfunction

	// r0 and the unused selects 38 to 63 read as zero
	function automatic word_t model_read(input reg_sel_t sel);
		if (sel == 6'd0 || int'(sel) >= reg_count) begin
			return '0;
		end
		return model_regs[sel];
	endfunction

	// ------------------------------
	// random numbers
	// ------------------------------

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic word_t random_bits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic reg_sel_t pick_reg();
		logic [2:0] idx;
		idx = 3'(random_bits(3));
		return targets[idx];
	endfunction

	// ------------------------------
	// checks
	// ------------------------------

	task automatic stop_on_error();
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic check_flags(input string name, input flags_t expected, input flags_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected nzvc %b, actual nzvc %b", name, expected, actual);
			stop_on_error();
		end
	endtask

	// fields packed as op, rd, op2, op3, rs1, bit 13, rs2 for the comparison
	task automatic check_ir(input string name, input word_t ir, input op_t op,
		input reg_addr_t rd, input op2_t op2, input op3_t op3, input reg_addr_t rs1,
		input logic bit13, input reg_addr_t rs2);
		logic [26:0] expected;
		logic [26:0] actual;
		expected = {ir[31:30], ir[29:25], ir[24:22], ir[24:19], ir[18:14], ir[13], ir[4:0]};
		actual = {op, rd, op2, op3, rs1, bit13, rs2};
		if (actual !== expected) begin
			$display("MISMATCH %s: expected fields %h, actual fields %h", name, expected, actual);
			stop_on_error();
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	// called 10 ns after an edge, returns 10 ns after the edge that executes the op
	task automatic run_op(input alu_op_t op, input reg_sel_t sel_a, input reg_sel_t sel_b,
		input reg_sel_t sel_w);
		word_t result;
		flags_t next_flags;
		result = ref_alu(op, model_read(sel_a), model_read(sel_b));
		next_flags = ref_flags(op, model_read(sel_a), model_read(sel_b), result);
		alu_op = op;
		read_sel_a = sel_a;
		read_sel_b = sel_b;
		write_sel = sel_w;
		@(posedge clock_50);
		#1;
		if (sel_w != 6'd0 && int'(sel_w) < reg_count) begin
			model_regs[sel_w] = result;
		end
		if (op inside {alu_andcc, alu_orcc, alu_orncc, alu_addcc}) begin
			model_flags = next_flags;
		end
		#9;
	endtask

	// builds a constant two bits at a time, shift left by two then inc per unit of the chunk
	task automatic load_value(input reg_sel_t target, input word_t value);
		logic [1:0] chunk;
		run_op(alu_and, 6'd0, 6'd0, target);
		for (int i = 15; i >= 0; i--) begin
			chunk = value[2*i +: 2];
			if (i != 15) begin
				run_op(alu_lshift2, target, 6'd0, target);
			end
			for (int k = 0; k < int'(chunk); k++) begin
				run_op(alu_inc, target, 6'd0, target);
			end
		end
	endtask

	// outputs settle right after the edge, so the middle of the low phase is safe
	always @(negedge clock_50) begin
		if (checking) begin
			check_word({test_name, " display"}, model_regs[1], display_bus);
			check_flags({test_name, " flags"}, model_flags, flags);
			check_ir({test_name, " ir"}, model_regs[reg_ir], ir_op, ir_rd, ir_op2, ir_op3,
				ir_rs1, ir_bit13, ir_rs2);
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
		$display("Regression failed");
		$fatal(1, "timeout");
	end

	initial begin
		word_t ir_word;
		arst_n = 1'b0;
		write_sel = '0;
		read_sel_a = '0;
		read_sel_b = '0;
		alu_op = alu_or;
		for (int i = 0; i < reg_count; i++) begin
			model_regs[i] = '0;
		end
		model_regs[reg_pc] = 32'h00000800;
		model_flags = '0;
		repeat (3) @(posedge clock_50);
		#10;
		arst_n = 1'b1;
		checking = 1'b1;

		// reset state, then pc copied through the ALU
		check_word("reset display", '0, display_bus);
		check_flags("reset flags", '0, flags);
		test_name = "pc copy";
		run_op(alu_or, reg_pc, 6'd0, 6'd1);
		check_word(test_name, 32'h00000800, display_bus);

		test_name = "load";
		for (int i = 0; i < load_count; i++) begin
			loaded[i] = random_bits(32);
			load_value(targets[i], loaded[i]);
			run_op(alu_or, targets[i], 6'd0, 6'd1);
			check_word(test_name, loaded[i], display_bus);
		end
		// r0 and the unused selects swallow writes and read as zero
		test_name = "dead selects";
		run_op(alu_or, targets[0], 6'd0, 6'd0);
		run_op(alu_or, targets[1], 6'd0, 6'd45);
		run_op(alu_or, targets[2], 6'd0, 6'd63);
		run_op(alu_or, 6'd0, 6'd50, 6'd1);
		check_word(test_name, '0, display_bus);
		run_op(alu_or, 6'd38, 6'd0, 6'd1);
		check_word(test_name, '0, display_bus);
		for (int i = 0; i < load_count; i++) begin
			run_op(alu_or, targets[i], 6'd0, 6'd1);
			check_word(test_name, loaded[i], display_bus);
		end

		for (int r = 0; r < alu_rounds; r++) begin
			for (int code = 0; code < 16; code++) begin
				test_name = $sformatf("alu op %0d", code);
				run_op(alu_op_t'(code), pick_reg(), pick_reg(), 6'd1);
			end
		end

		// r7 = 1, r8 = all ones, r9 = largest positive, r10 = most negative
		test_name = "flags";
		run_op(alu_inc, 6'd0, 6'd0, 6'd7);
		run_op(alu_orn, 6'd0, 6'd0, 6'd8);
		run_op(alu_srl, 6'd8, 6'd7, 6'd9);
		run_op(alu_orn, 6'd0, 6'd9, 6'd10);
		run_op(alu_addcc, 6'd9, 6'd7, 6'd1);
		check_flags("addcc overflow", 4'b1010, flags);
		run_op(alu_addcc, 6'd8, 6'd7, 6'd1);
		check_flags("addcc carry", 4'b0101, flags);
		run_op(alu_addcc, 6'd10, 6'd10, 6'd1);
		check_flags("addcc overflow and carry", 4'b0111, flags);
		run_op(alu_andcc, 6'd8, 6'd10, 6'd1);
		check_flags("andcc negative", 4'b1000, flags);
		run_op(alu_orcc, 6'd0, 6'd0, 6'd1);
		check_flags("orcc zero", 4'b0100, flags);
		run_op(alu_orncc, 6'd0, 6'd0, 6'd1);
		check_flags("orncc negative", 4'b1000, flags);
		for (int code = 4; code < 16; code++) begin
			run_op(alu_op_t'(code), pick_reg(), pick_reg(), 6'd1);
			check_flags($sformatf("flags hold op %0d", code), 4'b1000, flags);
		end

		test_name = "ir";
		for (int i = 0; i < ir_count; i++) begin
			ir_word = random_bits(32);
			load_value(reg_ir, ir_word);
			check_ir(test_name, ir_word, ir_op, ir_rd, ir_op2, ir_op3, ir_rs1, ir_bit13, ir_rs2);
		end

		// idle, and let the comparing process see the last result first
		write_sel = '0;
		alu_op = alu_or;
		@(negedge clock_50);
		#10;
		if (dut.u_alu.alu_checks.failures == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1, "%0d assertion failures in the ALU", dut.u_alu.alu_checks.failures);
		end
	end

endmodule

// File: filelist.f
arc_reg_pkg.sv
arc_alu_pkg.sv
register_file.sv
alu.sv
data_path.sv
tb_clock_gen.sv
alu_asserts.sv
data_path_tb.sv

// File: register_file.sv
// ARC register file

`timescale 1ns/1ps

module register_file
	import arc_reg_pkg::*;
#(
	parameter word_t pc_reset_value = 32'h00000800
) (
	input  logic      clock_50,
	input  logic      arst_n,
	input  reg_sel_t  write_sel,
	input  reg_sel_t  read_sel_a,
	input  reg_sel_t  read_sel_b,
	input  word_t     bus_c,
	output word_t     bus_a,
	output word_t     bus_b,
	output word_t     display_bus,
	output op_t       ir_op,
	output reg_addr_t ir_rd,
	output op2_t      ir_op2,
	output op3_t      ir_op3,
	output reg_addr_t ir_rs1,
	output logic      ir_bit13,
	output reg_addr_t ir_rs2
);

	// r1 is the register shown on the board display
	localparam reg_sel_t display_reg = 6'd1;

	// registers 1 to 37, r0 has no storage since it always reads zero
	word_t regs [1:reg_count-1];

	// one write enable per stored register
	logic [reg_count-1:1] write_en;

	// current contents of ir, split into fields below
	word_t ir_word;

	// ------------------------------
	// write decode
	// ------------------------------

	// at most one enable is set per cycle
	// select 0 and the unused selects 38 to 63 match no entry, so nothing is stored
	always_comb begin
		write_en = '0;
		for (int i = 1; i < reg_count; i++) begin
			if (write_sel == reg_sel_t'(i)) begin
				write_en[i] = 1'b1;
			end
		end
	end

	// ------------------------------
	// register storage
	// ------------------------------

	// every register clears to zero on reset except pc, which starts at the boot address
	// bus C is stored into the enabled register at the rising edge
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < reg_count; i++) begin
				if (i == int'(reg_pc)) begin
					regs[i] <= pc_reset_value;
				end else begin
					regs[i] <= '0;
				end
			end
		end else begin
			for (int i = 1; i < reg_count; i++) begin
				if (write_en[i]) begin
					regs[i] <= bus_c;
				end
			end
		end
	end

	// ------------------------------
	// read ports
	// ------------------------------

	// both buses are plain combinational multiplexers over the same array
	// a select of 0 or of 38 and above finds no entry and leaves the bus at zero
	always_comb begin
		bus_a = '0;
		bus_b = '0;
		for (int i = 1; i < reg_count; i++) begin
			if (read_sel_a == reg_sel_t'(i)) begin
				bus_a = regs[i];
			end
			if (read_sel_b == reg_sel_t'(i)) begin
				bus_b = regs[i];
			end
		end
	end

	// the display follows r1 directly, so a write to r1 shows one cycle later
	assign display_bus = regs[display_reg];

	// ------------------------------
	// instruction field decode
	// ------------------------------

	assign ir_word = regs[reg_ir];

	// op selects the instruction format
	assign ir_op    = ir_word[31:30];
	// destination register
	assign ir_rd    = ir_word[29:25];
	// op2 and op3 overlap, the control unit picks one by the format
	assign ir_op2   = ir_word[24:22];
	assign ir_op3   = ir_word[24:19];
	// first source register
	assign ir_rs1   = ir_word[18:14];
	// set when the second operand is the 13-bit immediate instead of rs2
	assign ir_bit13 = ir_word[13];
	// second source register, only meaningful when bit 13 is clear
	assign ir_rs2   = ir_word[4:0];

endmodule

// File: tb_clock_gen.sv
// Testbench clock source

`timescale 1ns/1ps

module tb_clock_gen #(
	// full clock period in ns
	parameter int period_ns = 100
) (
	output logic clock
);

	// starts low so the first rising edge comes half a period in
	initial begin
		clock = 1'b0;
		forever begin
			#(period_ns / 2) clock = ~clock;
		end
	end

endmodule
